// ==== bench/clock_gen.sv ====
//--------------------------------------------------
// Testbench clock, 8 ns period, and reset
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset   // Active low, held for the first 16 cycles
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // Half of the 8 ns period
	end

	initial begin
		reset = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b1;           // Released on a rising edge
	end
endmodule

`default_nettype wire

// ==== bench/cpu_controller_asserts.sv ====
//--------------------------------------------------
// Concurrent assertions on the controller strobes
// RAM access exclusion, single-cycle pulses, bind
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_controller_asserts (
	input wire clk,
	input wire reset,
	input wire wr,
	input wire rd,
	input wire w_en,
	input wire pc_en,
	input wire instr_done
);
	// RAM is never read and written in the same cycle
	wr_rd_exclusive: assert property (@(posedge clk) disable iff (!reset) !(wr && rd))
		else $error("wr and rd high in the same cycle");

	// Register file write never overlaps a RAM write
	w_en_wr_exclusive: assert property (@(posedge clk) disable iff (!reset) !(w_en && wr))
		else $error("w_en and wr high in the same cycle");

	pc_en_single: assert property (@(posedge clk) disable iff (!reset) pc_en |=> !pc_en)
		else $error("pc_en held for more than one cycle");   // One increment per instruction

	instr_done_single: assert property (@(posedge clk) disable iff (!reset)
		instr_done |=> !instr_done)
		else $error("instr_done held for more than one cycle");
endmodule

bind cpu_controller cpu_controller_asserts cpu_controller_asserts_inst (
	.clk(clk), .reset(reset), .wr(wr), .rd(rd), .w_en(w_en),
	.pc_en(pc_en), .instr_done(instr_done)
);

`default_nettype wire

// ==== bench/tb_cpu_controller.sv ====
//--------------------------------------------------
// Testbench for the sequencing controller
// Random instruction stream, reference model,
// pulse counting compare process, check task, watchdog
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_config.svh"

module tb_cpu_controller;
	import ctrl_pkg::*;

	localparam int NUM_INSTR    = 40;
	localparam int RESET_CYCLES = 16;   // Same as clock_gen
	localparam int QUIET_CYCLES = 12;   // go low windows before and after the stream
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + RESET_CYCLES + 2 * QUIET_CYCLES + 8;
	localparam int SEED         = 69207;
	localparam int NUM_STROBES  = 10;

	// Bit positions in the strobe vector
	typedef enum int {
		IDX_MAR, IDX_PC_FETCH, IDX_PC_EN, IDX_W_EN, IDX_IR_EN,
		IDX_LD_EN, IDX_ST_EN, IDX_MDR_EN, IDX_WR, IDX_RD
	} strobe_idx_t;

	typedef enum int {CLS_ALU, CLS_LOAD, CLS_STORE, CLS_UNSUP} instr_class_t;

	logic   clk, reset, go;
	instr_t ir;
	logic   mar_en, pc_fetch, pc_en, w_en, ir_en;
	logic   ld_en, st_en, mdr_en, wr, rd, instr_done;
	logic [NUM_STROBES-1:0] strobes;
	logic [NUM_STROBES-1:0] prev_strobes;
	logic [31:0]            out_word;      // All outputs for the quiet checks

	int rise_count [NUM_STROBES];
	int first_rise [NUM_STROBES];          // Cycle of the first rise or -1
	int last_fall  [NUM_STROBES];
	int cycle_count   = 0;
	int checked_count = 0;

	assign strobes  = {rd, wr, mdr_en, st_en, ld_en, ir_en, w_en, pc_en, pc_fetch, mar_en};
	assign out_word = {21'd0, instr_done, strobes};

	clock_gen clock_gen_inst (.clk(clk), .reset(reset));

	cpu_controller cpu_controller_inst (.*);

	//--------------------------------------------------
	// Reference model
	//--------------------------------------------------
	function automatic instr_class_t class_of(instr_t word);
		logic [2:0] op;
		op = word[`CTRL_OP_MSB:`CTRL_OP_LSB];
		if (word[`CTRL_CLASS_BIT])
			return CLS_ALU;
		else if (op == `CTRL_OP_LOAD)
			return CLS_LOAD;
		else if (op == `CTRL_OP_STORE)
			return CLS_STORE;
		return CLS_UNSUP;                  // 011 and 1xx
	endfunction

	// Expected rising edges of one strobe over one instruction
	function automatic int expected_rises(instr_t word, int idx);
		instr_class_t cls;
		int n;
		cls = class_of(word);
		case (idx)
			IDX_PC_FETCH, IDX_PC_EN, IDX_IR_EN: n = 1;   // Fetch and PC increment
			IDX_MAR:    n = (cls == CLS_LOAD || cls == CLS_STORE) ? 2 : 1;
			IDX_RD:     n = (cls == CLS_LOAD) ? 2 : 1;    // Fetch read plus data read
			IDX_W_EN:   n = (cls == CLS_ALU || cls == CLS_LOAD) ? 1 : 0;
			IDX_LD_EN:  n = (cls == CLS_LOAD) ? 1 : 0;
			IDX_MDR_EN: n = (cls == CLS_LOAD || cls == CLS_STORE) ? 1 : 0;
			IDX_ST_EN, IDX_WR: n = (cls == CLS_STORE) ? 1 : 0;
			default:    n = 0;
		endcase
		return n;
	endfunction

	// Random word where the first four cover each class once
	function automatic instr_t make_instr(int n);
		instr_t word;
		int     cls;
		word = $urandom;
		cls  = (n < 4) ? n : int'($urandom_range(3, 0));
		word[`CTRL_CLASS_BIT] = (cls == 0);
		case (cls)
			1: word[`CTRL_OP_MSB:`CTRL_OP_LSB] = `CTRL_OP_LOAD;
			2: word[`CTRL_OP_MSB:`CTRL_OP_LSB] = `CTRL_OP_STORE;
			3: word[`CTRL_OP_MSB:`CTRL_OP_LSB] = 3'($urandom_range(7, 3));
			default: ;
		endcase
		return word;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic clear_counts();
		for (int i = 0; i < NUM_STROBES; i++) begin
			rise_count[i] = 0;
			first_rise[i] = -1;
			last_fall[i]  = -1;
		end
	endtask

	task automatic check_instruction(input instr_t word);
		string        tag;
		strobe_idx_t  sid;
		instr_class_t cls;
		tag = $sformatf("instr%0d", checked_count);
		cls = class_of(word);
		for (int i = 0; i < NUM_STROBES; i++) begin
			sid = strobe_idx_t'(i);
			check_value($sformatf("%s_%s_pulses", tag, sid.name()),
				expected_rises(word, i), rise_count[i]);
		end
		// Staged fetch order pc_fetch then mar_en then rd then ir_en
		check_value({tag, "_fetch_order"}, 1,
			(first_rise[IDX_PC_FETCH] < first_rise[IDX_MAR] &&
			 first_rise[IDX_MAR] < first_rise[IDX_RD] &&
			 first_rise[IDX_RD] < first_rise[IDX_IR_EN]) ? 1 : 0);
		if (cls == CLS_LOAD)
			check_value({tag, "_w_en_after_ld_en"}, 1,
				(first_rise[IDX_W_EN] > last_fall[IDX_LD_EN]) ? 1 : 0);
		if (cls == CLS_STORE)
			check_value({tag, "_wr_after_st_en"}, 1,
				(last_fall[IDX_ST_EN] >= 0 &&
				 first_rise[IDX_WR] >= last_fall[IDX_ST_EN]) ? 1 : 0);
	endtask

	task automatic wait_instr_done();
		@(posedge clk);
		while (instr_done !== 1'b1)
			@(posedge clk);
	endtask

	//--------------------------------------------------
	// Compare process counting edges between instr_done pulses
	//--------------------------------------------------
	always @(posedge clk) begin : compare_proc
		if (!reset) begin
			clear_counts();
			prev_strobes = '0;
		end else begin
			cycle_count++;
			for (int i = 0; i < NUM_STROBES; i++) begin
				if (strobes[i] && !prev_strobes[i]) begin
					rise_count[i]++;
					if (first_rise[i] < 0)
						first_rise[i] = cycle_count;
				end
				if (!strobes[i] && prev_strobes[i])
					last_fall[i] = cycle_count;
			end
			prev_strobes = strobes;
			if (instr_done) begin                 // ir still holds this instruction
				check_instruction(ir);
				checked_count++;
				clear_counts();
			end
		end
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	initial begin : stimulus
		go = 1'b0;
		ir = '0;
		void'($urandom(SEED));
		while (reset !== 1'b1) begin
			@(posedge clk);
			check_value("reset_quiet", 0, out_word);
		end
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			check_value("go_low_quiet", 0, out_word);
		end
		@(posedge clk);
		ir <= make_instr(0);
		go <= 1'b1;
		for (int n = 1; n < NUM_INSTR; n++) begin
			wait_instr_done();
			ir <= make_instr(n);                  // Next word at each instr_done
		end
		// Drop go in the middle of the last instruction
		@(posedge clk);
		while (pc_en !== 1'b1)
			@(posedge clk);
		go <= 1'b0;
		wait_instr_done();
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			check_value("after_go_low_quiet", 0, out_word);
		end
		check_value("instr_checked", NUM_INSTR, checked_count);
		$display("Everything OK");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout, run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end
endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/ctrl_bus_if.sv
rtl/fetch_seq.sv
rtl/load_seq.sv
rtl/store_seq.sv
rtl/op_dispatch.sv
rtl/cycle_sequencer.sv
rtl/cpu_controller.sv
bench/clock_gen.sv
bench/cpu_controller_asserts.sv
bench/tb_cpu_controller.sv

// ==== rtl/cpu_controller.sv ====
//--------------------------------------------------
// Multicycle CPU sequencing controller, top level
// Loop, fetch, dispatch, load and store sequencers
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_controller (
	input wire                clk,
	input wire                reset,
	input wire                go,
	input wire ctrl_pkg::instr_t  ir,
	output logic              mar_en,
	output logic              pc_fetch,
	output logic              pc_en,
	output logic              w_en,
	output logic              ir_en,
	output logic              ld_en,
	output logic              st_en,
	output logic              mdr_en,
	output logic              wr,
	output logic              rd,
	output logic              instr_done
);
	// Start and done pulse pairs
	logic fetch_start, fetch_done;
	logic exec_start, exec_done;
	logic load_start, load_done;
	logic store_start, store_done;

	ctrl_bus_if fetch_bus ();
	ctrl_bus_if load_bus ();
	ctrl_bus_if store_bus ();
	ctrl_bus_if exec_bus ();

	cycle_sequencer cycle_sequencer_inst (
		.clk(clk), .reset(reset), .go(go),
		.fetch_done(fetch_done), .exec_done(exec_done),
		.fetch_bus(fetch_bus.sink), .exec_bus(exec_bus.sink),
		.fetch_start(fetch_start), .exec_start(exec_start), .instr_done(instr_done),
		.mar_en(mar_en), .pc_fetch(pc_fetch), .pc_en(pc_en), .w_en(w_en),
		.ir_en(ir_en), .ld_en(ld_en), .st_en(st_en), .mdr_en(mdr_en),
		.wr(wr), .rd(rd)
	);

	fetch_seq fetch_seq_inst (
		.clk(clk), .reset(reset), .start(fetch_start),
		.done(fetch_done), .bus(fetch_bus.source)
	);

	op_dispatch op_dispatch_inst (
		.clk(clk), .reset(reset), .start(exec_start), .ir(ir),
		.load_done(load_done), .store_done(store_done),
		.load_bus(load_bus.sink), .store_bus(store_bus.sink),
		.done(exec_done), .load_start(load_start), .store_start(store_start),
		.bus(exec_bus.source)
	);

	load_seq load_seq_inst (
		.clk(clk), .reset(reset), .start(load_start),
		.done(load_done), .bus(load_bus.source)
	);

	store_seq store_seq_inst (
		.clk(clk), .reset(reset), .start(store_start),
		.done(store_done), .bus(store_bus.source)
	);
endmodule

`default_nettype wire

// ==== rtl/ctrl_bus_if.sv ====
//--------------------------------------------------
// Datapath control strobe bundle
// Source and sink modports
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ctrl_bus_if;
	logic mar_en;     // MAR load
	logic pc_fetch;   // MAR takes its address from the PC
	logic pc_en;      // PC load
	logic w_en;       // Register file write
	logic ir_en;      // IR load
	logic ld_en;      // MDR takes data from RAM
	logic st_en;      // MDR takes data from the register file
	logic mdr_en;     // MDR load
	logic wr;         // RAM write
	logic rd;         // RAM read

	modport source (output mar_en, pc_fetch, pc_en, w_en, ir_en,
		ld_en, st_en, mdr_en, wr, rd);
	modport sink (input mar_en, pc_fetch, pc_en, w_en, ir_en,
		ld_en, st_en, mdr_en, wr, rd);
endinterface

`default_nettype wire

// ==== rtl/ctrl_config.svh ====
//--------------------------------------------------
// Instruction word layout for the controller
// Word width, class bit, operation field, opcodes
//--------------------------------------------------
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Width of the instruction word
`define CTRL_IR_WIDTH   32
// Set for ALU class instructions
`define CTRL_CLASS_BIT  31
// Operation field position
`define CTRL_OP_LSB     26
`define CTRL_OP_MSB     28
// Memory class operation codes
`define CTRL_OP_LOAD    3'b000
`define CTRL_OP_STORE   3'b001

`endif

// ==== rtl/ctrl_pkg.sv ====
//--------------------------------------------------
// Shared types of the sequencing controller
// Instruction word, operation field, FSM state enums
//--------------------------------------------------
`default_nettype none
`include "ctrl_config.svh"

package ctrl_pkg;

	typedef logic [`CTRL_IR_WIDTH-1:0] instr_t;               // Held instruction word
	typedef logic [`CTRL_OP_MSB-`CTRL_OP_LSB:0] op_field_t;   // Operation field

	//--------------------------------------------------
	// Sequencer states
	//--------------------------------------------------
	typedef enum logic [2:0] {
		F_IDLE, F_PC, F_MAR, F_RD, F_IR, F_DONE
	} fetch_state_t;

	typedef enum logic [2:0] {
		L_IDLE, L_MAR, L_RD, L_LDEN, L_MDR, L_GAP, L_WEN, L_DONE
	} load_state_t;

	typedef enum logic [2:0] {
		S_IDLE, S_STEN, S_ADDR, S_WR, S_DONE
	} store_state_t;

	// Execute dispatch, one sequence per instruction
	typedef enum logic [2:0] {
		E_IDLE, E_DECODE, E_ALU, E_WAIT, E_DONE
	} exec_state_t;

	// Instruction loop
	typedef enum logic [2:0] {
		C_IDLE, C_FETCH_START, C_FETCH_WAIT, C_PC_INC,
		C_EXEC_START, C_EXEC_WAIT, C_INSTR_DONE
	} cycle_state_t;

endpackage

`default_nettype wire

// ==== rtl/cycle_sequencer.sv ====
//--------------------------------------------------
// Instruction loop FSM with PC increment
// Registered merge of all datapath strobes
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
	input wire         clk,
	input wire         reset,
	input wire         go,           // Level, run while high
	input wire         fetch_done,
	input wire         exec_done,
	ctrl_bus_if.sink   fetch_bus,
	ctrl_bus_if.sink   exec_bus,
	output logic       fetch_start,
	output logic       exec_start,
	output logic       instr_done,
	output logic       mar_en,
	output logic       pc_fetch,
	output logic       pc_en,
	output logic       w_en,
	output logic       ir_en,
	output logic       ld_en,
	output logic       st_en,
	output logic       mdr_en,
	output logic       wr,
	output logic       rd
);
	import ctrl_pkg::*;

	cycle_state_t state, state_nxt;
	logic         pc_inc;   // Own PC increment strobe

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= C_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			C_IDLE:        if (go) state_nxt = C_FETCH_START;
			C_FETCH_START: state_nxt = C_FETCH_WAIT;
			C_FETCH_WAIT:  if (fetch_done) state_nxt = C_PC_INC;
			C_PC_INC:      state_nxt = C_EXEC_START;
			C_EXEC_START:  state_nxt = C_EXEC_WAIT;
			C_EXEC_WAIT:   if (exec_done) state_nxt = C_INSTR_DONE;
			default:       state_nxt = C_IDLE;   // go is sampled again in idle
		endcase
	end

	assign fetch_start = (state == C_FETCH_START);
	assign exec_start  = (state == C_EXEC_START);
	assign pc_inc      = (state == C_PC_INC);

	//--------------------------------------------------
	// Output registers, one cycle behind the FSMs
	//--------------------------------------------------
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			{mar_en, pc_fetch, pc_en, w_en, ir_en} <= '0;
			{ld_en, st_en, mdr_en, wr, rd} <= '0;
			instr_done <= 1'b0;
		end else begin
			mar_en     <= fetch_bus.mar_en | exec_bus.mar_en;
			pc_fetch   <= fetch_bus.pc_fetch | exec_bus.pc_fetch;
			pc_en      <= fetch_bus.pc_en | exec_bus.pc_en | pc_inc;
			w_en       <= fetch_bus.w_en | exec_bus.w_en;
			ir_en      <= fetch_bus.ir_en | exec_bus.ir_en;
			ld_en      <= fetch_bus.ld_en | exec_bus.ld_en;
			st_en      <= fetch_bus.st_en | exec_bus.st_en;
			mdr_en     <= fetch_bus.mdr_en | exec_bus.mdr_en;
			wr         <= fetch_bus.wr | exec_bus.wr;
			rd         <= fetch_bus.rd | exec_bus.rd;
			instr_done <= (state == C_INSTR_DONE);   // End of instruction pulse
		end
	end
endmodule

`default_nettype wire

// ==== rtl/fetch_seq.sv ====
//--------------------------------------------------
// Staged instruction fetch sequencer
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_seq (
	input wire          clk,
	input wire          reset,
	input wire          start,   // One-cycle pulse from the loop FSM
	output logic        done,
	ctrl_bus_if.source  bus
);
	import ctrl_pkg::*;

	fetch_state_t state, state_nxt;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= F_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			F_IDLE:  if (start) state_nxt = F_PC;   // Start only taken when idle
			F_PC:    state_nxt = F_MAR;
			F_MAR:   state_nxt = F_RD;
			F_RD:    state_nxt = F_IR;
			F_IR:    state_nxt = F_DONE;
			default: state_nxt = F_IDLE;            // F_DONE returns to idle
		endcase
	end

	// Strobes build up one per cycle and all drop in F_DONE
	assign bus.pc_fetch = (state inside {F_PC, F_MAR, F_RD, F_IR});
	assign bus.mar_en   = (state inside {F_MAR, F_RD, F_IR});
	assign bus.rd       = (state inside {F_RD, F_IR});
	assign bus.ir_en    = (state == F_IR);
	assign bus.pc_en    = 1'b0;
	assign bus.w_en     = 1'b0;
	assign bus.ld_en    = 1'b0;
	assign bus.st_en    = 1'b0;
	assign bus.mdr_en   = 1'b0;
	assign bus.wr       = 1'b0;

	assign done = (state == F_DONE);
endmodule

`default_nettype wire

// ==== rtl/load_seq.sv ====
//--------------------------------------------------
// Load sequencer, RAM to MDR to register file
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_seq (
	input wire          clk,
	input wire          reset,
	input wire          start,
	output logic        done,
	ctrl_bus_if.source  bus
);
	import ctrl_pkg::*;

	load_state_t state, state_nxt;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= L_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			L_IDLE:  if (start) state_nxt = L_MAR;
			L_MAR:   state_nxt = L_RD;     // Address into the MAR
			L_RD:    state_nxt = L_LDEN;
			L_LDEN:  state_nxt = L_MDR;
			L_MDR:   state_nxt = L_GAP;    // MDR captures the read word
			L_GAP:   state_nxt = L_WEN;
			L_WEN:   state_nxt = L_DONE;
			default: state_nxt = L_IDLE;
		endcase
	end

	assign bus.mar_en   = (state == L_MAR);
	assign bus.rd       = (state inside {L_RD, L_LDEN, L_MDR});
	assign bus.ld_en    = (state inside {L_LDEN, L_MDR});
	assign bus.mdr_en   = (state == L_MDR);
	assign bus.w_en     = (state == L_WEN);   // Writeback after the MDR settles
	assign bus.pc_fetch = 1'b0;
	assign bus.pc_en    = 1'b0;
	assign bus.ir_en    = 1'b0;
	assign bus.st_en    = 1'b0;
	assign bus.wr       = 1'b0;

	assign done = (state == L_DONE);
endmodule

`default_nettype wire

// ==== rtl/op_dispatch.sv ====
//--------------------------------------------------
// Instruction decode and execute dispatch
// ALU writeback, load and store start, strobe merge
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_config.svh"

module op_dispatch (
	input wire               clk,
	input wire               reset,
	input wire               start,
	input wire ctrl_pkg::instr_t  ir,   // Held stable for the whole instruction
	input wire               load_done,
	input wire               store_done,
	ctrl_bus_if.sink         load_bus,
	ctrl_bus_if.sink         store_bus,
	output logic             done,
	output logic             load_start,
	output logic             store_start,
	ctrl_bus_if.source       bus
);
	import ctrl_pkg::*;

	exec_state_t state, state_nxt;
	op_field_t   op;
	logic        alu_class;
	logic        is_load;
	logic        is_store;

	// Decode of the class bit and operation field
	assign alu_class = ir[`CTRL_CLASS_BIT];
	assign op        = ir[`CTRL_OP_MSB:`CTRL_OP_LSB];
	assign is_load   = !alu_class && (op == `CTRL_OP_LOAD);
	assign is_store  = !alu_class && (op == `CTRL_OP_STORE);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= E_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			E_IDLE: if (start) state_nxt = E_DECODE;
			E_DECODE: begin
				if (alu_class)
					state_nxt = E_ALU;
				else if (is_load || is_store)
					state_nxt = E_WAIT;   // Child sequencer started here
				else
					state_nxt = E_DONE;   // Unsupported, no execute strobes
			end
			E_ALU:   state_nxt = E_DONE;
			E_WAIT:  if (load_done || store_done) state_nxt = E_DONE;
			default: state_nxt = E_IDLE;
		endcase
	end

	// At most one child is started per instruction
	assign load_start  = (state == E_DECODE) && is_load;
	assign store_start = (state == E_DECODE) && is_store;
	assign done        = (state == E_DONE);

	//--------------------------------------------------
	// Strobe merge
	//--------------------------------------------------
	assign bus.w_en     = load_bus.w_en | store_bus.w_en | (state == E_ALU);
	assign bus.mar_en   = load_bus.mar_en | store_bus.mar_en;
	assign bus.pc_fetch = load_bus.pc_fetch | store_bus.pc_fetch;
	assign bus.pc_en    = load_bus.pc_en | store_bus.pc_en;
	assign bus.ir_en    = load_bus.ir_en | store_bus.ir_en;
	assign bus.ld_en    = load_bus.ld_en | store_bus.ld_en;
	assign bus.st_en    = load_bus.st_en | store_bus.st_en;
	assign bus.mdr_en   = load_bus.mdr_en | store_bus.mdr_en;
	assign bus.wr       = load_bus.wr | store_bus.wr;
	assign bus.rd       = load_bus.rd | store_bus.rd;
endmodule

`default_nettype wire

// ==== rtl/store_seq.sv ====
//--------------------------------------------------
// Store sequencer, register file to RAM
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module store_seq (
	input wire          clk,
	input wire          reset,
	input wire          start,
	output logic        done,
	ctrl_bus_if.source  bus
);
	import ctrl_pkg::*;

	store_state_t state, state_nxt;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:  if (start) state_nxt = S_STEN;
			S_STEN:  state_nxt = S_ADDR;
			S_ADDR:  state_nxt = S_WR;    // MAR and MDR load together
			S_WR:    state_nxt = S_DONE;
			default: state_nxt = S_IDLE;
		endcase
	end

	assign bus.st_en    = (state inside {S_STEN, S_ADDR});
	assign bus.mar_en   = (state == S_ADDR);
	assign bus.mdr_en   = (state == S_ADDR);
	assign bus.wr       = (state == S_WR);   // RAM write once st_en has dropped
	assign bus.pc_fetch = 1'b0;
	assign bus.pc_en    = 1'b0;
	assign bus.w_en     = 1'b0;
	assign bus.ir_en    = 1'b0;
	assign bus.ld_en    = 1'b0;
	assign bus.rd       = 1'b0;

	assign done = (state == S_DONE);
endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_cpu_controller -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
